/* Bender.yml */
package:
  name: crc_ahb

sources:
  - files:
      - src/crc_pkg.sv
      - src/crc_host_interface.sv
      - src/crc_input_buffer.sv
      - src/crc_engine.sv
      - src/crc_ahb_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/crc_ahb_assertions.sv
      - sim/tb_crc_ahb.sv

/* crc_ahb_top.f */
src/crc_pkg.sv
src/crc_host_interface.sv
src/crc_input_buffer.sv
src/crc_engine.sv
src/crc_ahb_top.sv
sim/tb_clock_gen.sv
sim/crc_ahb_assertions.sv
sim/tb_crc_ahb.sv

/* sim/crc_ahb_assertions.sv */
/*
 * Concurrent bus checks for the CRC host interface.
 * Bound into every crc_host_interface instance; the count of failed
 * assertions is read by the testbench at the end of the run.
 */

`timescale 1ns/1ps

module crc_ahb_assertions
(
	input logic       HCLK,
	input logic       HRESETn,
	input logic       hsel_q,
	input logic [1:0] htrans_q,
	input logic [2:0] haddr_q,
	input logic       hwrite_q,
	input logic       read_wait,
	input logic       HREADYOUT,
	input logic       HRESP
);

	import crc_pkg::*;

	int unsigned assert_failures = 0;
	logic        dr_read_phase;

	// Data phase of a NONSEQ read of DR
	assign dr_read_phase = hsel_q && !hwrite_q && (htrans_q == NONSEQ) && (haddr_q == DR);

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////
	// No error responses at all
	hresp_okay: assert property (@(posedge HCLK) HRESP == 1'b0)
	else
	begin
		assert_failures++;
		$error("HRESP is not OKAY");
	end

	// Pipeline is cleared by reset
	ready_after_reset: assert property (@(posedge HCLK) !HRESETn |=> HREADYOUT)
	else
	begin
		assert_failures++;
		$error("HREADYOUT low right after reset");
	end

	// Result not final yet, so DR read must stall
	dr_read_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_read_phase && read_wait) |-> !HREADYOUT)
	else
	begin
		assert_failures++;
		$error("DR read completed while read_wait was high");
	end

endmodule

bind crc_host_interface crc_ahb_assertions i_assertions
(
	.HCLK      (HCLK),
	.HRESETn   (HRESETn),
	.hsel_q    (hsel_q),
	.htrans_q  (htrans_q),
	.haddr_q   (haddr_q),
	.hwrite_q  (hwrite_q),
	.read_wait (read_wait),
	.HREADYOUT (HREADYOUT),
	.HRESP     (HRESP)
);

/* sim/tb_clock_gen.sv */
/*
 * Clock and reset source for the CRC testbench.
 * HCLK runs with a 4 ns period, HRESETn is held low for 16 cycles.
 */

`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int RESET_CYCLES = 16
)
(
	output logic HCLK,
	output logic HRESETn
);

	// 4 ns period
	initial
	begin
		HCLK = 1'b0;
		forever #2 HCLK = ~HCLK;
	end

	// Release on a falling edge, away from the sampling edge
	initial
	begin
		HRESETn = 1'b0;
		repeat (RESET_CYCLES) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
	end

endmodule

/* sim/tb_crc_ahb.sv */
/*
 * Testbench for the AHB-Lite CRC peripheral.
 * Drives single NONSEQ transfers, models the expected CRC from the
 * register settings and the DR byte stream, and compares all reads.
 */

`timescale 1ns/1ps

module tb_crc_ahb;

	import crc_pkg::*;

	localparam int          READY_TIMEOUT = 64;
	localparam int          RESET_TIMEOUT = 64;
	localparam int          DRAIN_TIMEOUT = 64;
	// Galois taps, x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	logic [31:0] lfsr_state = 32'h1e43_3ddc;
	int          stall_cycles = 0;

	// Model of the register contents
	logic [31:0] model_init = CRC_INIT_DEFAULT;
	logic [31:0] model_poly = CRC_POLY_DEFAULT;
	logic [31:0] model_idr = 32'h0;
	poly_size_t  model_size = POLY32;
	rev_in_t     model_rev_in = REV_NONE;
	logic        model_rev_out = 1'b0;
	// DR writes since the last reset command
	logic [31:0] stream_data[$];
	logic [1:0]  stream_size[$];

	// Pending comparisons
	string       exp_name_q[$];
	logic [31:0] exp_value_q[$];
	logic [31:0] obs_value_q[$];

	tb_clock_gen i_clock
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn)
	);

	crc_ahb_top i_dut
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSEL      (HSEL),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	//////////////////////////////////////////////////
	// Random data and reference model
	//////////////////////////////////////////////////
	// One LFSR step per returned bit
	function automatic logic [31:0] lfsr_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return r;
	endfunction

	// Code 3 is not a legal size here
	function automatic logic [1:0] random_size();
		logic [1:0] pick;
		pick = lfsr_bits(2);
		return (pick == 2'd3) ? SIZE_WORD : pick;
	endfunction

	function automatic logic [31:0] cr_value(poly_size_t ps, rev_in_t ri, logic ro, logic rst);
		return {24'h0, ro, ri, ps, 2'b00, rst};
	endfunction

	// CRC over the queued DR writes, starting from INIT
	function automatic logic [31:0] crc_reference(logic [31:0] init, logic [31:0] poly,
		poly_size_t psize, rev_in_t rin, logic rout, logic [31:0] data[$],
		logic [1:0] sizes[$]);
		int          width;
		int          nbytes;
		int          unit;
		logic [31:0] mask;
		logic [31:0] crc;
		logic [31:0] word;
		logic [31:0] res;
		logic        fb;
		case (psize)
			POLY16:  width = 16;
			POLY8:   width = 8;
			POLY7:   width = 7;
			default: width = 32;
		endcase
		mask = (width == 32) ? 32'hffff_ffff : ((32'd1 << width) - 32'd1);
		crc  = init & mask;
		foreach (data[k])
		begin
			nbytes = (sizes[k] == SIZE_BYTE) ? 1 : (sizes[k] == SIZE_HALF) ? 2 : 4;
			// Reversal field in bits, never wider than the write
			case (rin)
				REV_BYTE: unit = 8;
				REV_HALF: unit = 16;
				REV_WORD: unit = 32;
				default:  unit = 1;
			endcase
			if (unit > nbytes * 8)
				unit = nbytes * 8;
			word = '0;
			for (int i = 0; i < nbytes * 8; i++)
				word[i] = data[k][(i / unit) * unit + unit - 1 - (i % unit)];
			// Low byte first, each byte MSB first
			for (int b = 0; b < nbytes; b++)
			begin
				for (int i = 7; i >= 0; i--)
				begin
					fb  = crc[width - 1] ^ word[b * 8 + i];
					crc = (crc << 1) & mask;
					if (fb)
						crc = crc ^ (poly & mask);
				end
			end
		end
		res = crc;
		if (rout)
		begin
			res = '0;
			for (int i = 0; i < width; i++)
				res[i] = crc[width - 1 - i];
		end
		return res;
	endfunction

	function automatic logic [31:0] expected_dr();
		return crc_reference(model_init, model_poly, model_size, model_rev_in,
			model_rev_out, stream_data, stream_size);
	endfunction

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////
	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at time %0t: %s read %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	task automatic fail_run(string reason);
		$display("%s at time %0t", reason, $time);
		$display("Test failed");
		$fatal(1, "Run aborted");
	endtask

	// Compare process, one entry per completed read
	always @(posedge HCLK)
	begin
		while (obs_value_q.size() > 0)
		begin
			check_value(exp_name_q.pop_front(), obs_value_q.pop_front(),
				exp_value_q.pop_front());
		end
		// Bound protocol assertions
		if (i_dut.i_host.i_assertions.assert_failures != 0)
			fail_run("Bus assertion failed");
	end

	//////////////////////////////////////////////////
	// AHB driver
	//////////////////////////////////////////////////
	// Address phase, then data phase with IDLE on the address bus
	task automatic bus_transfer(logic write, logic [2:0] addr, logic [1:0] size,
		logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		@(negedge HCLK);
		HSEL   = 1'b1;
		HADDR  = {27'h0, addr, 2'b00};
		HTRANS = NONSEQ;
		HWRITE = write;
		HSIZE  = {1'b0, size};
		@(negedge HCLK);
		HSEL   = 1'b0;
		HTRANS = IDLE;
		HWRITE = 1'b0;
		HWDATA = write ? wdata : 32'h0;
		// Only slave on the bus
		HREADY = HREADYOUT;
		waited = 0;
		while (!HREADYOUT)
		begin
			waited++;
			if (waited > READY_TIMEOUT)
				fail_run("Timeout waiting for HREADYOUT");
			@(negedge HCLK);
			HREADY = HREADYOUT;
		end
		rdata = HRDATA;
		stall_cycles += waited;
	endtask

	task automatic write_reg(logic [2:0] addr, logic [31:0] data);
		logic [31:0] rdata_ignored;
		bus_transfer(1'b1, addr, SIZE_WORD, data, rdata_ignored);
	endtask

	task automatic write_dr(logic [1:0] size, logic [31:0] data);
		write_reg_sized(size, data);
		stream_data.push_back(data);
		stream_size.push_back(size);
	endtask

	task automatic write_reg_sized(logic [1:0] size, logic [31:0] data);
		logic [31:0] rdata_ignored;
		bus_transfer(1'b1, DR, size, data, rdata_ignored);
	endtask

	task automatic read_and_expect(string name, logic [2:0] addr, logic [31:0] exp);
		logic [31:0] got;
		bus_transfer(1'b0, addr, SIZE_WORD, 32'h0, got);
		exp_name_q.push_back(name);
		exp_value_q.push_back(exp);
		obs_value_q.push_back(got);
	endtask

	// CR write with the reset command, stream restarts from INIT
	task automatic configure(poly_size_t ps, rev_in_t ri, logic ro);
		write_reg(CR, cr_value(ps, ri, ro, 1'b1));
		model_size    = ps;
		model_rev_in  = ri;
		model_rev_out = ro;
		stream_data.delete();
		stream_size.delete();
	endtask

	//////////////////////////////////////////////////
	// Scenarios
	//////////////////////////////////////////////////
	initial
	begin : stimulus
		logic [31:0] data;
		logic [1:0]  size;
		logic [1:0]  pick;
		int          waited;
		int          stalls_before;
		HSEL   = 1'b0;
		HADDR  = 32'h0;
		HTRANS = IDLE;
		HSIZE  = 3'd0;
		HWRITE = 1'b0;
		HWDATA = 32'h0;
		HREADY = 1'b1;
		waited = 0;
		while (HRESETn !== 1'b1)
		begin
			waited++;
			if (waited > RESET_TIMEOUT)
				fail_run("Reset was never released");
			@(negedge HCLK);
		end

		// Reset values and IDR scratch byte
		read_and_expect("INIT", INIT, CRC_INIT_DEFAULT);
		read_and_expect("POL", POL, CRC_POLY_DEFAULT);
		read_and_expect("CR", CR, 32'h0);
		read_and_expect("DR", DR, expected_dr());
		model_idr = lfsr_bits(8);
		write_reg(IDR, model_idr);
		read_and_expect("IDR", IDR, model_idr);

		// Back to back words, CRC-32 defaults
		configure(POLY32, REV_NONE, 1'b0);
		stalls_before = stall_cycles;
		repeat (16)
		begin
			data = lfsr_bits(32);
			write_dr(SIZE_WORD, data);
		end
		if (stall_cycles == stalls_before)
			fail_run("No wait state seen on back-to-back DR writes");
		read_and_expect("DR", DR, expected_dr());

		// Every input reversal mode, output reversal off and on
		for (int m = 0; m < 4; m++)
		begin
			for (int o = 0; o < 2; o++)
			begin
				configure(POLY32, rev_in_t'(m), o[0]);
				read_and_expect("CR", CR, cr_value(model_size, model_rev_in, o[0], 1'b0));
				repeat (6)
				begin
					size = random_size();
					data = lfsr_bits(32);
					write_dr(size, data);
				end
				read_and_expect("DR", DR, expected_dr());
			end
		end

		// Narrow polynomials with random POL and INIT
		for (int s = 1; s < 4; s++)
		begin
			model_poly = lfsr_bits(32);
			model_init = lfsr_bits(32);
			write_reg(POL, model_poly);
			write_reg(INIT, model_init);
			read_and_expect("POL", POL, model_poly);
			pick = lfsr_bits(2);
			configure(poly_size_t'(s), rev_in_t'(pick), lfsr_bits(1));
			repeat (5)
			begin
				size = random_size();
				data = lfsr_bits(32);
				write_dr(size, data);
			end
			read_and_expect("DR", DR, expected_dr());
		end

		// Reset command behind DR writes, INIT written straight after
		configure(POLY32, REV_NONE, 1'b0);
		repeat (3)
		begin
			data = lfsr_bits(32);
			write_dr(SIZE_WORD, data);
		end
		configure(POLY32, REV_NONE, 1'b0);
		data = lfsr_bits(32);
		write_reg(INIT, data);
		// Old INIT was loaded before the write went through
		read_and_expect("DR after reset command", DR, expected_dr());
		model_init = data;
		read_and_expect("INIT", INIT, model_init);
		configure(POLY32, REV_NONE, 1'b0);
		read_and_expect("DR after second reset", DR, expected_dr());

		// Unmapped words 3, 6 and 7
		read_and_expect("word 3", 3'd3, 32'h0);
		read_and_expect("word 6", 3'd6, 32'h0);
		read_and_expect("word 7", 3'd7, 32'h0);
		write_reg(3'd3, lfsr_bits(32));
		write_reg(3'd6, lfsr_bits(32));
		write_reg(3'd7, lfsr_bits(32));
		read_and_expect("INIT", INIT, model_init);
		read_and_expect("POL", POL, model_poly);
		read_and_expect("IDR", IDR, model_idr);
		read_and_expect("CR", CR, cr_value(model_size, model_rev_in, model_rev_out, 1'b0));
		read_and_expect("DR", DR, expected_dr());

		// Let the compare process catch up
		waited = 0;
		while (obs_value_q.size() > 0)
		begin
			waited++;
			if (waited > DRAIN_TIMEOUT)
				fail_run("Compare queue did not drain");
			@(negedge HCLK);
		end
		if (i_dut.i_host.i_assertions.assert_failures == 0)
			$display("Test completed successfully");
		else
		begin
			$display("Assertion failures %0d", i_dut.i_host.i_assertions.assert_failures);
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* src/crc_ahb_top.sv */
/*
 * Top level of the AHB-Lite CRC peripheral.
 * Connects the bus front end, the input buffer and the CRC engine;
 * INIT_RESET and POLY_RESET set the reset values of INIT and POL.
 */

`timescale 1ns/1ps

module crc_ahb_top
#(
	parameter logic [31:0] INIT_RESET = crc_pkg::CRC_INIT_DEFAULT,
	parameter logic [31:0] POLY_RESET = crc_pkg::CRC_POLY_DEFAULT
)
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	import crc_pkg::*;

	// Bus side strobes and data
	logic [31:0] bus_wdata;
	bus_size_t   bus_size;
	logic        buf_write;
	logic        init_write;
	logic        idr_write;
	logic        poly_write;
	logic        reset_chain;

	// Configuration
	poly_size_t  poly_size;
	rev_in_t     rev_in;
	logic        rev_out;

	// Buffer to engine
	logic        buffer_full;
	logic        buf_valid;
	logic [31:0] buf_data;
	bus_size_t   buf_size;
	logic        buf_take;

	// Engine status and read back
	logic [31:0] crc_result;
	logic [31:0] init_value;
	logic [7:0]  idr_value;
	logic [31:0] poly_value;
	logic        reset_pending;
	logic        read_wait;

	crc_host_interface i_host
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.HSEL          (HSEL),
		.HADDR         (HADDR),
		.HTRANS        (HTRANS),
		.HSIZE         (HSIZE),
		.HWRITE        (HWRITE),
		.HWDATA        (HWDATA),
		.HREADY        (HREADY),
		.buffer_full   (buffer_full),
		.read_wait     (read_wait),
		.reset_pending (reset_pending),
		.crc_result    (crc_result),
		.init_value    (init_value),
		.idr_value     (idr_value),
		.poly_value    (poly_value),
		.HRDATA        (HRDATA),
		.HREADYOUT     (HREADYOUT),
		.HRESP         (HRESP),
		.bus_wdata     (bus_wdata),
		.bus_size      (bus_size),
		.buf_write     (buf_write),
		.init_write    (init_write),
		.idr_write     (idr_write),
		.poly_write    (poly_write),
		.reset_chain   (reset_chain),
		.poly_size     (poly_size),
		.rev_in        (rev_in),
		.rev_out       (rev_out)
	);

	crc_input_buffer i_buffer
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.buf_write   (buf_write),
		.bus_wdata   (bus_wdata),
		.bus_size    (bus_size),
		.buf_take    (buf_take),
		.buffer_full (buffer_full),
		.buf_valid   (buf_valid),
		.buf_data    (buf_data),
		.buf_size    (buf_size)
	);

	crc_engine
	#(
		.INIT_RESET (INIT_RESET),
		.POLY_RESET (POLY_RESET)
	)
	i_engine
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.bus_wdata     (bus_wdata),
		.init_write    (init_write),
		.idr_write     (idr_write),
		.poly_write    (poly_write),
		.reset_chain   (reset_chain),
		.poly_size     (poly_size),
		.rev_in        (rev_in),
		.rev_out       (rev_out),
		.buf_valid     (buf_valid),
		.buf_data      (buf_data),
		.buf_size      (buf_size),
		.buf_take      (buf_take),
		.crc_result    (crc_result),
		.init_value    (init_value),
		.idr_value     (idr_value),
		.poly_value    (poly_value),
		.reset_pending (reset_pending),
		.read_wait     (read_wait)
	);

endmodule

/* src/crc_engine.sv */
/*
 * Byte-serial CRC engine with programmable polynomial and width.
 * Holds INIT, POL and IDR, applies input and output bit reversal and
 * handles the CR reset command once all queued data is consumed.
 */

`timescale 1ns/1ps

module crc_engine
#(
	parameter logic [31:0] INIT_RESET = crc_pkg::CRC_INIT_DEFAULT,
	parameter logic [31:0] POLY_RESET = crc_pkg::CRC_POLY_DEFAULT
)
(
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  logic [31:0]          bus_wdata,
	input  logic                 init_write,
	input  logic                 idr_write,
	input  logic                 poly_write,
	input  logic                 reset_chain,
	input  crc_pkg::poly_size_t  poly_size,
	input  crc_pkg::rev_in_t     rev_in,
	input  logic                 rev_out,
	input  logic                 buf_valid,
	input  logic [31:0]          buf_data,
	input  crc_pkg::bus_size_t   buf_size,
	output logic                 buf_take,
	output logic [31:0]          crc_result,
	output logic [31:0]          init_value,
	output logic [7:0]           idr_value,
	output logic [31:0]          poly_value,
	output logic                 reset_pending,
	output logic                 read_wait
);

	import crc_pkg::*;

	typedef enum logic {IDLE, SHIFT} eng_state_t;

	eng_state_t  state;
	logic [1:0]  byte_cnt;
	logic [31:0] data_q;
	logic [31:0] crc_q;
	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	logic        pending_q;
	logic        reset_apply;
	logic [31:0] crc_masked;
	logic [4:0]  crc_top;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	// Index of the CRC MSB for the selected width
	function automatic logic [4:0] width_top(poly_size_t size);
		case (size)
			POLY16:  return 5'd15;
			POLY8:   return 5'd7;
			POLY7:   return 5'd6;
			default: return 5'd31;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(poly_size_t size);
		return 32'hffff_ffff >> (5'd31 - width_top(size));
	endfunction

	// Reversal unit is capped at the written size
	function automatic logic [31:0] reverse_input(logic [31:0] d, rev_in_t mode,
		bus_size_t size);
		logic [31:0] rb;
		logic [31:0] rh;
		logic [31:0] rw;
		for (int i = 0; i < 32; i++)
		begin
			rb[i] = d[(i / 8) * 8 + 7 - (i % 8)];
			rh[i] = d[(i / 16) * 16 + 15 - (i % 16)];
			rw[i] = d[31 - i];
		end
		case (mode)
			REV_BYTE: return rb;
			REV_HALF: return (size == SIZE_BYTE) ? rb : rh;
			REV_WORD: return (size == SIZE_BYTE) ? rb : (size == SIZE_HALF) ? rh : rw;
			default:  return d;
		endcase
	endfunction

	// Eight MSB-first steps, byte bit 7 enters first
	function automatic logic [31:0] crc_byte(logic [31:0] crc, logic [7:0] din,
		logic [31:0] poly, poly_size_t size);
		logic [31:0] c;
		logic [31:0] mask;
		logic [4:0]  top;
		logic        fb;
		mask = width_mask(size);
		top  = width_top(size);
		c    = crc & mask;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[top] ^ din[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	// Queued data drains ahead of a pending reset
	assign buf_take    = (state == IDLE) && buf_valid;
	assign reset_apply = pending_q && (state == IDLE) && !buf_valid;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state     <= IDLE;
			byte_cnt  <= 2'd0;
			pending_q <= 1'b0;
			crc_q     <= INIT_RESET;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (buf_take)
					begin
						state <= SHIFT;
						// Remaining bytes minus one
						case (buf_size)
							SIZE_BYTE: byte_cnt <= 2'd0;
							SIZE_HALF: byte_cnt <= 2'd1;
							default:   byte_cnt <= 2'd3;
						endcase
					end
				end
				default:
				begin
					if (byte_cnt == 2'd0)
						state <= IDLE;
					else
						byte_cnt <= byte_cnt - 2'd1;
				end
			endcase
			// A fresh command keeps the reset pending
			if (reset_chain)
				pending_q <= 1'b1;
			else if (reset_apply)
				pending_q <= 1'b0;
			if (reset_apply)
				crc_q <= init_q;
			else if (state == SHIFT)
				crc_q <= crc_byte(crc_q, data_q[7:0], poly_q, poly_size);
		end
	end

	// Shift register, least significant byte first
	always_ff @(posedge HCLK)
	begin
		if (buf_take)
			data_q <= reverse_input(buf_data, rev_in, buf_size);
		else if (state == SHIFT)
			data_q <= data_q >> 8;
	end

	//////////////////////////////////////////////////
	// Registers and outputs
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= INIT_RESET;
			poly_q <= POLY_RESET;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (init_write)
				init_q <= bus_wdata;
			if (poly_write)
				poly_q <= bus_wdata;
			if (idr_write)
				idr_q <= bus_wdata[7:0];
		end
	end

	// Result masked to width, optionally mirrored within it
	assign crc_top    = width_top(poly_size);
	assign crc_masked = crc_q & width_mask(poly_size);
	assign crc_result = rev_out ? ({<<{crc_masked}} >> (5'd31 - crc_top)) : crc_masked;

	assign init_value    = init_q;
	assign poly_value    = poly_q;
	assign idr_value     = idr_q;
	assign reset_pending = pending_q;
	// DR is not final while data or a reset is outstanding
	assign read_wait     = (state == SHIFT) || buf_valid || pending_q;

endmodule

/* src/crc_host_interface.sv */
/*
 * AHB-Lite slave front end of the CRC peripheral.
 * Registers the address phase, decodes the register map, holds CR,
 * muxes read data and stretches the data phase with wait states.
 */

`timescale 1ns/1ps

module crc_host_interface
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic                    HSEL,
	input  logic [31:0]             HADDR,
	input  logic [1:0]              HTRANS,
	input  logic [2:0]              HSIZE,
	input  logic                    HWRITE,
	input  logic [31:0]             HWDATA,
	input  logic                    HREADY,
	input  logic                    buffer_full,
	input  logic                    read_wait,
	input  logic                    reset_pending,
	input  logic [31:0]             crc_result,
	input  logic [31:0]             init_value,
	input  logic [7:0]              idr_value,
	input  logic [31:0]             poly_value,
	output logic [31:0]             HRDATA,
	output logic                    HREADYOUT,
	output logic                    HRESP,
	output logic [31:0]             bus_wdata,
	output crc_pkg::bus_size_t      bus_size,
	output logic                    buf_write,
	output logic                    init_write,
	output logic                    idr_write,
	output logic                    poly_write,
	output logic                    reset_chain,
	output crc_pkg::poly_size_t     poly_size,
	output crc_pkg::rev_in_t        rev_in,
	output logic                    rev_out
);

	import crc_pkg::*;

	// Address phase pipeline
	logic       hsel_q;
	htrans_t    htrans_q;
	logic [2:0] haddr_q;
	logic       hwrite_q;
	bus_size_t  hsize_q;

	// CR fields
	poly_size_t poly_size_q;
	rev_in_t    rev_in_q;
	logic       rev_out_q;

	logic sample_bus;
	logic write_en;
	logic read_en;
	logic dr_write_en;
	logic dr_read_en;
	logic init_write_en;
	logic cr_write;

	//////////////////////////////////////////////////
	// Address phase
	//////////////////////////////////////////////////
	// A new transfer is only accepted when the bus is ready
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			htrans_q <= IDLE;
		end
		else if (sample_bus)
		begin
			hsel_q   <= HSEL;
			htrans_q <= htrans_t'(HTRANS);
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_q  <= HADDR[4:2];
			hwrite_q <= HWRITE;
			hsize_q  <= bus_size_t'(HSIZE[1:0]);
		end
	end

	//////////////////////////////////////////////////
	// Decode and strobes
	//////////////////////////////////////////////////
	// BUSY, SEQ and IDLE beats complete with no effect
	assign write_en = hsel_q && hwrite_q && (htrans_q == NONSEQ);
	assign read_en  = hsel_q && !hwrite_q && (htrans_q == NONSEQ);

	assign dr_write_en   = write_en && (haddr_q == DR);
	assign dr_read_en    = read_en && (haddr_q == DR);
	assign init_write_en = write_en && (haddr_q == INIT);
	assign cr_write      = write_en && (haddr_q == CR);

	// New data also waits behind a pending reset
	assign buf_write  = dr_write_en && !buffer_full && !reset_pending;
	// INIT is only updated once the pending reset has used the old value
	assign init_write = init_write_en && !reset_pending;
	assign idr_write  = write_en && (haddr_q == IDR);
	assign poly_write = write_en && (haddr_q == POL);

	// Write data is taken straight from the data phase
	assign bus_wdata = HWDATA;
	assign bus_size  = hsize_q;

	//////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_size_q <= POLY32;
			rev_in_q    <= REV_NONE;
			rev_out_q   <= 1'b0;
		end
		else if (cr_write)
		begin
			poly_size_q <= poly_size_t'(HWDATA[4:3]);
			rev_in_q    <= rev_in_t'(HWDATA[6:5]);
			rev_out_q   <= HWDATA[7];
		end
	end

	// Bit 0 is a command, never stored
	assign reset_chain = cr_write && HWDATA[0];
	assign poly_size   = poly_size_q;
	assign rev_in      = rev_in_q;
	assign rev_out     = rev_out_q;

	// Read data, unmapped words give zero
	always_comb
	begin
		case (haddr_q)
			DR:      HRDATA = crc_result;
			IDR:     HRDATA = {24'h0, idr_value};
			CR:      HRDATA = {24'h0, rev_out_q, rev_in_q, poly_size_q, 3'b000};
			INIT:    HRDATA = init_value;
			POL:     HRDATA = poly_value;
			default: HRDATA = 32'h0;
		endcase
	end

	// Wait states
	assign HREADYOUT = !((dr_write_en && (buffer_full || reset_pending)) ||
		(dr_read_en && read_wait) ||
		(init_write_en && reset_pending));

	// Always OKAY
	assign HRESP = 1'b0;

endmodule

/* src/crc_input_buffer.sv */
/*
 * Single-entry holding register between the bus and the CRC engine.
 * Captures a DR write word with its size and presents it until the
 * engine takes it; a new word may enter in the same cycle.
 */

`timescale 1ns/1ps

module crc_input_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                buf_write,
	input  logic [31:0]         bus_wdata,
	input  crc_pkg::bus_size_t  bus_size,
	input  logic                buf_take,
	output logic                buffer_full,
	output logic                buf_valid,
	output logic [31:0]         buf_data,
	output crc_pkg::bus_size_t  buf_size
);

	import crc_pkg::*;

	logic        valid_q;
	logic [31:0] data_q;
	bus_size_t   size_q;

	//////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////
	// A write in the take cycle keeps the entry occupied
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			valid_q <= 1'b0;
		end
		else if (buf_write)
		begin
			valid_q <= 1'b1;
		end
		else if (buf_take)
		begin
			valid_q <= 1'b0;
		end
	end

	// Word and size
	always_ff @(posedge HCLK)
	begin
		if (buf_write)
		begin
			data_q <= bus_wdata;
			size_q <= bus_size;
		end
	end

	// Slot frees up in the cycle the engine takes it
	assign buffer_full = valid_q && !buf_take;

	assign buf_valid = valid_q;
	assign buf_data  = data_q;
	assign buf_size  = size_q;

endmodule

/* src/crc_pkg.sv */
/*
 * Shared definitions for the AHB-Lite CRC peripheral.
 * Register word addresses, AHB transfer and size codes, CR field
 * encodings and the reset values used by the top level.
 */

package crc_pkg;

	//////////////////////////////////////////////////
	// Register map, word address HADDR[4:2]
	//////////////////////////////////////////////////
	typedef enum logic [2:0]
	{
		DR   = 3'd0,
		IDR  = 3'd1,
		CR   = 3'd2,
		INIT = 3'd4,
		POL  = 3'd5
	} crc_reg_t;

	//////////////////////////////////////////////////
	// AHB encodings
	//////////////////////////////////////////////////
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Low two bits of HSIZE
	typedef enum logic [1:0]
	{
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} bus_size_t;

	//////////////////////////////////////////////////
	// CR fields
	//////////////////////////////////////////////////
	// CR[4:3]
	typedef enum logic [1:0] {POLY32, POLY16, POLY8, POLY7} poly_size_t;
	// CR[6:5]
	typedef enum logic [1:0] {REV_NONE, REV_BYTE, REV_HALF, REV_WORD} rev_in_t;

	// Reset values of INIT and POL
	localparam logic [31:0] CRC_INIT_DEFAULT = 32'hffff_ffff;
	// Ethernet CRC-32, normal form
	localparam logic [31:0] CRC_POLY_DEFAULT = 32'h04c1_1db7;

endpackage
